// ==== testbench/credit_rx_stim.txt ====
# Columns: opcode flow data expected, all hex.
# stall flow 0 = pop stall, 1 = credit stall, 2 = held pop stall level; data = cycles or level.
expect_credits 0 0 4
expect_credits 1 0 4
expect_credits 2 0 4
expect_credits 3 0 4
push 0 a000 0
push 1 b001 0
push 2 c002 0
push 3 d003 0
push 0 a004 0
push 0 a005 0
push 1 b006 0
push 0 a007 0
stall 0 8 0
push 0 a008 0
push 2 c009 0
push 3 d00a 0
drain 0 0 b
expect_credits 0 0 4
expect_credits 1 0 4
expect_credits 2 0 4
expect_credits 3 0 4
push 1 b010 0
push 1 b011 0
push 1 b012 0
push 1 b013 0
push 1 b014 0
push 2 c015 0
push 3 d016 0
push 0 a017 0
drain 0 0 8
withhold 0 2 0
stall 2 1 0
push 2 c020 0
push 3 d021 0
push 3 d022 0
sreset 1 2 3
stall 2 0 0
expect_credits 0 0 2
expect_credits 1 0 2
expect_credits 2 0 2
expect_credits 3 0 2
withhold 0 0 0
stall 1 6 0
expect_credits 0 0 4
expect_credits 1 0 4
expect_credits 2 0 4
expect_credits 3 0 4
push 0 a030 0
push 1 b031 0
push 2 c032 0
push 3 d033 0
drain 0 0 4

// ==== verilog.f ====
hdl/credit_rx_pkg.sv
hdl/lane_if.sv
hdl/flow_demux.sv
hdl/credit_lane.sv
hdl/pop_arbiter.sv
hdl/credit_rx_top.sv
testbench/tb_clock_gen.sv
testbench/credit_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= credit_rx_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/credit_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module credit_rx_tb;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   push_sender_in_reset;
  logic                                   push_receiver_in_reset;
  logic                                   push_credit_stall;
  logic [credit_rx_pkg::NUM_FLOWS-1:0]    push_credit;
  logic                                   push_valid;
  logic [credit_rx_pkg::FLOW_W-1:0]       push_flow;
  credit_rx_pkg::payload_t                push_data;
  logic [credit_rx_pkg::CNT_W-1:0]        credit_withhold;
  logic [credit_rx_pkg::NUM_FLOWS-1:0][credit_rx_pkg::CNT_W-1:0] credit_count;
  logic                                   pop_stall;
  logic                                   pop_valid;
  logic [credit_rx_pkg::FLOW_W-1:0]       pop_flow;
  credit_rx_pkg::payload_t                pop_data;

  // ----------------------------------------------------------------------
  // Sender model state
  // ----------------------------------------------------------------------

  // Credits the sender holds per flow, and the items still in flight.
  int                      balance [credit_rx_pkg::NUM_FLOWS];
  credit_rx_pkg::payload_t model_q [credit_rx_pkg::NUM_FLOWS][$];

  // Stim lines, already parsed.
  string       ops [$];
  logic [31:0] flows [$];
  logic [31:0] datas [$];
  logic [31:0] exps [$];

  int   popped;
  int   cycle_count;
  int   cycle_limit;
  logic hold_stall;
  logic expect_no_pop;
  logic expect_no_credit;

  tb_clock_gen u_tb_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  credit_rx_top u_credit_rx_top (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_receiver_in_reset (push_receiver_in_reset),
    .push_credit_stall      (push_credit_stall),
    .push_credit            (push_credit),
    .push_valid             (push_valid),
    .push_flow              (push_flow),
    .push_data              (push_data),
    .credit_withhold        (credit_withhold),
    .credit_count           (credit_count),
    .pop_stall              (pop_stall),
    .pop_valid              (pop_valid),
    .pop_flow               (pop_flow),
    .pop_data               (pop_data)
  );

  // ----------------------------------------------------------------------
  // Reporting
  // ----------------------------------------------------------------------

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s actual 0x%0h expected 0x%0h", name, actual, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Cycle counter, armed once the stim budget is known.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      report_failure($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  // While the local reset is held, no credit and no item may leave the
  // receiver, and the receiver reports its reset to the sender.
  // The registered outputs only settle once the first edge has passed.
  always @(negedge clk) begin
    if (cycle_count > 0) begin
      if (rst_n === 1'b0) begin
        check_value("push_credit", 32'(push_credit), 32'h0);
        check_value("pop_valid", 32'(pop_valid), 32'h0);
        check_value("push_receiver_in_reset", 32'(push_receiver_in_reset), 32'h1);
      end else begin
        // The sender's own reset is never echoed back.
        check_value("push_receiver_in_reset", 32'(push_receiver_in_reset), 32'h0);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Cycle helpers
  // ----------------------------------------------------------------------

  function automatic int items_in_flight();
    int total;
    total = 0;
    for (int f = 0; f < credit_rx_pkg::NUM_FLOWS; f++) begin
      total += model_q[f].size();
    end
    return total;
  endfunction

  // Random pop stall on top of the held level.
  function automatic logic pick_pop_stall();
    return hold_stall || (($urandom % 4) == 0);
  endfunction

  // Samples this cycle's outputs mid-cycle, then moves to just after the
  // next rising edge, where the caller drives the inputs again.
  task automatic advance_cycle();
    @(negedge clk);
    for (int f = 0; f < credit_rx_pkg::NUM_FLOWS; f++) begin
      if (push_credit[f]) begin
        balance[f]++;
      end
    end
    if (expect_no_credit) begin
      check_value("push_credit", 32'(push_credit), 32'h0);
    end
    if (expect_no_pop) begin
      check_value("pop_valid", 32'(pop_valid), 32'h0);
    end
    if (pop_valid) begin
      if (model_q[pop_flow].size() == 0) begin
        report_failure($sformatf("item popped on flow %0d that was never pushed", pop_flow));
      end
      check_value("pop_data", 32'(pop_data), 32'(model_q[pop_flow].pop_front()));
      popped++;
    end
    @(posedge clk);
    #1;
  endtask

  // Sends one item once a credit for its flow is held.
  task automatic send_item(input int f, input credit_rx_pkg::payload_t d);
    int gap;
    while (balance[f] == 0) begin
      pop_stall = pick_pop_stall();
      advance_cycle();
    end
    push_valid = 1'b1;
    push_flow  = credit_rx_pkg::FLOW_W'(f);
    push_data  = d;
    balance[f]--;
    model_q[f].push_back(d);
    pop_stall = pick_pop_stall();
    advance_cycle();
    push_valid = 1'b0;
    gap = $urandom % 3;
    repeat (gap) begin
      pop_stall = pick_pop_stall();
      advance_cycle();
    end
  endtask

  // ----------------------------------------------------------------------
  // Stim file
  // ----------------------------------------------------------------------

  task automatic load_stim();
    int          fd;
    string       line;
    string       op;
    logic [31:0] fl;
    logic [31:0] da;
    logic [31:0] ex;
    int          budget;
    fd = $fopen("testbench/credit_rx_stim.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the stim file");
    end
    budget = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Comment and blank lines do not yield four fields.
      if ($sscanf(line, "%s %h %h %h", op, fl, da, ex) == 4) begin
        ops.push_back(op);
        flows.push_back(fl);
        datas.push_back(da);
        exps.push_back(ex);
        case (op)
          "push":           budget += 8;
          "stall":          budget += int'(da) + 1;
          "sreset":         budget += int'(da) + 2;
          "drain":          budget += 40;
          "expect_credits": budget += 20;
          default:          budget += 0;
        endcase
      end
    end
    $fclose(fd);
    cycle_limit = 4 * budget + 200;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    push_sender_in_reset = 1'b0;
    push_credit_stall    = 1'b0;
    push_valid           = 1'b0;
    push_flow            = '0;
    push_data            = '0;
    credit_withhold      = '0;
    pop_stall            = 1'b0;
    popped               = 0;
    cycle_limit          = 0;
    hold_stall           = 1'b0;
    expect_no_pop        = 1'b0;
    expect_no_credit     = 1'b0;
    for (int f = 0; f < credit_rx_pkg::NUM_FLOWS; f++) begin
      balance[f] = 0;
    end
    void'($urandom(32'hfb4ca507));
    load_stim();

    wait (rst_n === 1'b1);

    for (int i = 0; i < ops.size(); i++) begin
      case (ops[i])
        "push": begin
          send_item(int'(flows[i]), datas[i][credit_rx_pkg::DATA_W-1:0]);
        end
        "stall": begin
          if (flows[i] == 0) begin
            // A stall in cycle c leaves pop_valid low from c+1 on.
            pop_stall = 1'b1;
            for (int c = 0; c < int'(datas[i]); c++) begin
              expect_no_pop = (c > 0);
              advance_cycle();
            end
            expect_no_pop = 1'b0;
            pop_stall     = hold_stall;
          end else if (flows[i] == 1) begin
            pop_stall         = hold_stall;
            push_credit_stall = 1'b1;
            expect_no_credit  = 1'b1;
            repeat (int'(datas[i])) advance_cycle();
            push_credit_stall = 1'b0;
            expect_no_credit  = 1'b0;
          end else begin
            hold_stall = datas[i][0];
            pop_stall  = hold_stall;
          end
        end
        "withhold": begin
          credit_withhold = datas[i][credit_rx_pkg::CNT_W-1:0];
        end
        "sreset": begin
          check_value("buffered_items", 32'(items_in_flight()), exps[i]);
          // The sender's own reset forgets every credit it held.
          for (int f = 0; f < credit_rx_pkg::NUM_FLOWS; f++) begin
            balance[f] = 0;
          end
          push_sender_in_reset = 1'b1;
          expect_no_credit     = 1'b1;
          repeat (int'(datas[i])) begin
            push_valid = 1'b1;
            push_flow  = credit_rx_pkg::FLOW_W'(flows[i]);
            push_data  = 16'hdead;
            advance_cycle();
          end
          push_valid           = 1'b0;
          push_sender_in_reset = 1'b0;
          expect_no_credit     = 1'b0;
          for (int f = 0; f < credit_rx_pkg::NUM_FLOWS; f++) begin
            model_q[f].delete();
          end
          popped = 0;
          // First cycle out of reset carries no push.
          advance_cycle();
        end
        "drain": begin
          pop_stall = 1'b0;
          while (items_in_flight() > 0) begin
            advance_cycle();
          end
          // Every lane is empty now, so nothing more may come out.
          expect_no_pop = 1'b1;
          repeat (4) advance_cycle();
          expect_no_pop = 1'b0;
          check_value("drained_items", 32'(popped), exps[i]);
          popped = 0;
        end
        "expect_credits": begin
          pop_stall = hold_stall;
          repeat (20) advance_cycle();
          // Credits held plus items in flight is what the lane has let out.
          check_value("outstanding_credits",
                      32'(balance[flows[i]] + model_q[flows[i]].size()), exps[i]);
          check_value("credit_count", 32'(credit_count[flows[i]]),
                      32'(credit_rx_pkg::LANE_DEPTH) - exps[i]);
        end
        default: begin
          report_failure($sformatf("unknown stim opcode %s", ops[i]));
        end
      endcase
    end

    check_value("items_left", 32'(items_in_flight()), 32'h0);
    $display("sim passed");
    $finish;
  end

endmodule : credit_rx_tb

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free-running clock with a 100 ns period and a power-on reset.
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is held low for three rising edges.
  // It is released just after an edge, like every other driven input.
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== hdl/credit_rx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module credit_rx_top (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,

  // Push side, towards the sender.
  input  wire logic                                  push_sender_in_reset,
  output logic                                       push_receiver_in_reset,
  input  wire logic                                  push_credit_stall,
  output logic [credit_rx_pkg::NUM_FLOWS-1:0]        push_credit,
  input  wire logic                                  push_valid,
  input  wire logic [credit_rx_pkg::FLOW_W-1:0]      push_flow,
  input  wire credit_rx_pkg::payload_t               push_data,

  // Credit control and status, same withhold for every lane.
  input  wire logic [credit_rx_pkg::CNT_W-1:0]       credit_withhold,
  output logic [credit_rx_pkg::NUM_FLOWS-1:0][credit_rx_pkg::CNT_W-1:0] credit_count,

  // Pop side, one item per high cycle of pop_valid.
  input  wire logic                                  pop_stall,
  output logic                                       pop_valid,
  output logic [credit_rx_pkg::FLOW_W-1:0]           pop_flow,
  output credit_rx_pkg::payload_t                    pop_data
);

  // ----------------------------------------------------------------------
  // Reset combination
  // ----------------------------------------------------------------------

  // Either side in reset puts every lane in reset.
  // That keeps the credit view of both ends consistent.
  logic lane_rst;

  assign lane_rst = !rst_n || push_sender_in_reset;

  // Tells the sender that this end is in reset.
  assign push_receiver_in_reset = !rst_n;

  // ----------------------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------------------

  lane_if lane_bus [credit_rx_pkg::NUM_FLOWS] ();

  flow_demux u_flow_demux (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_rst   (lane_rst),
    .push_valid (push_valid),
    .push_flow  (push_flow),
    .push_data  (push_data),
    .lanes      (lane_bus)
  );

  // One credit counter and buffer per flow.
  for (genvar i = 0; i < credit_rx_pkg::NUM_FLOWS; i++) begin : g_lane
    credit_lane u_credit_lane (
      .clk               (clk),
      .lane_rst          (lane_rst),
      .push_credit_stall (push_credit_stall),
      .credit_withhold   (credit_withhold),
      .lane              (lane_bus[i]),
      .push_credit       (push_credit[i]),
      .credit_count      (credit_count[i])
    );
  end

  // Drains the lanes onto the registered pop strobe.
  pop_arbiter u_pop_arbiter (
    .clk       (clk),
    .lane_rst  (lane_rst),
    .pop_stall (pop_stall),
    .lanes     (lane_bus),
    .pop_valid (pop_valid),
    .pop_flow  (pop_flow),
    .pop_data  (pop_data)
  );

endmodule : credit_rx_top

`default_nettype wire

// ==== hdl/pop_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module pop_arbiter (
  input  wire logic                          clk,
  input  wire logic                          lane_rst,
  input  wire logic                          pop_stall,
  lane_if.arb                                lanes [credit_rx_pkg::NUM_FLOWS],
  output logic                               pop_valid,
  output logic [credit_rx_pkg::FLOW_W-1:0]   pop_flow,
  output credit_rx_pkg::payload_t            pop_data
);

  // ----------------------------------------------------------------------
  // Lane view
  // ----------------------------------------------------------------------

  // Flat copies of the lane heads, so the pick can index them freely.
  logic [credit_rx_pkg::NUM_FLOWS-1:0] head_valid;
  credit_rx_pkg::payload_t             head_data [credit_rx_pkg::NUM_FLOWS];

  // Lane granted most recently; the search starts just after it.
  logic [credit_rx_pkg::FLOW_W-1:0]    last_q;
  // Lane picked this cycle and whether any lane was picked at all.
  logic [credit_rx_pkg::FLOW_W-1:0]    grant_idx;
  logic                                grant_found;
  logic                                grant_valid;

  for (genvar i = 0; i < credit_rx_pkg::NUM_FLOWS; i++) begin : g_lane
    assign head_valid[i] = lanes[i].head_valid;
    assign head_data[i]  = lanes[i].head_data;
    // Dequeue is a single pulse to the granted lane only.
    assign lanes[i].deq  = grant_valid && (grant_idx == credit_rx_pkg::FLOW_W'(i));
  end

  // ----------------------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------------------

  // Walk the lanes in order, starting one past the last grant.
  always_comb begin
    logic [credit_rx_pkg::FLOW_W-1:0] cand;
    cand        = '0;
    grant_idx   = last_q;
    grant_found = 1'b0;
    for (int k = 1; k <= credit_rx_pkg::NUM_FLOWS; k++) begin
      cand = credit_rx_pkg::FLOW_W'((int'(last_q) + k) % credit_rx_pkg::NUM_FLOWS);
      if (!grant_found && head_valid[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // Stall and reset both keep every lane untouched this cycle.
  assign grant_valid = grant_found && !pop_stall && !lane_rst;

  // The pointer only moves on a grant.
  // After reset it sits on the last lane, so lane 0 is tried first.
  always_ff @(posedge clk) begin
    if (lane_rst) begin
      pop_valid <= 1'b0;
      last_q    <= credit_rx_pkg::FLOW_W'(credit_rx_pkg::NUM_FLOWS - 1);
    end else begin
      pop_valid <= grant_valid;
      if (grant_valid) begin
        last_q <= grant_idx;
      end
    end
  end

  // Output payload, loaded with the granted head.
  always_ff @(posedge clk) begin
    if (grant_valid) begin
      pop_flow <= grant_idx;
      pop_data <= head_data[grant_idx];
    end
  end

endmodule : pop_arbiter

`default_nettype wire

// ==== hdl/credit_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module credit_lane (
  input  wire logic                          clk,
  input  wire logic                          lane_rst,
  input  wire logic                          push_credit_stall,
  input  wire logic [credit_rx_pkg::CNT_W-1:0] credit_withhold,
  lane_if.lane                               lane,
  output logic                               push_credit,
  output logic [credit_rx_pkg::CNT_W-1:0]    credit_count
);

  // ----------------------------------------------------------------------
  // Lane buffer
  // ----------------------------------------------------------------------

  // Storage for the items of this flow.
  credit_rx_pkg::payload_t mem [credit_rx_pkg::LANE_DEPTH];

  // Read and write pointers carry one extra wrap bit.
  // Equal pointers mean empty, which is all the lane ever needs to know,
  // because the sender never pushes without a credit.
  logic [credit_rx_pkg::PTR_W:0] wr_ptr_q;
  logic [credit_rx_pkg::PTR_W:0] rd_ptr_q;

  // Pointer bookkeeping.
  // Reset empties the buffer; the entries themselves are left as they are.
  always_ff @(posedge clk) begin
    if (lane_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (lane.push_valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (lane.deq) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Write the pushed item at the current write slot.
  always_ff @(posedge clk) begin
    if (lane.push_valid) begin
      mem[wr_ptr_q[credit_rx_pkg::PTR_W-1:0]] <= lane.push_data;
    end
  end

  // The head entry is offered as soon as it has been written.
  assign lane.head_valid = (wr_ptr_q != rd_ptr_q);
  assign lane.head_data  = mem[rd_ptr_q[credit_rx_pkg::PTR_W-1:0]];

  // ----------------------------------------------------------------------
  // Credit counter
  // ----------------------------------------------------------------------

  // Credits still held by the receiver for this flow.
  // Count plus credits with the sender plus buffered items always add up
  // to LANE_DEPTH.
  logic [credit_rx_pkg::CNT_W-1:0] count_q;

  // Count plus this cycle's dequeue, one bit wider so it cannot wrap.
  logic [credit_rx_pkg::CNT_W:0]   credit_sum;
  // Credit that may be released now, after withhold, never below zero.
  logic [credit_rx_pkg::CNT_W:0]   credit_avail;
  // One credit goes out this cycle.
  logic                            credit_grant;
  // Counter value for the next cycle.
  logic [credit_rx_pkg::CNT_W-1:0] count_next;

  // A slot freed in this cycle counts right away.
  // That lets a credit go back out in the same cycle its entry leaves.
  assign credit_sum = {1'b0, count_q} + {{credit_rx_pkg::CNT_W{1'b0}}, lane.deq};

  // Withhold is taken off the top of what the lane holds.
  always_comb begin
    if (credit_sum > {1'b0, credit_withhold}) begin
      credit_avail = credit_sum - {1'b0, credit_withhold};
    end else begin
      credit_avail = '0;
    end
  end

  // At most one credit per cycle.
  // The sender's stall and either reset hold it back.
  assign credit_grant = (credit_avail != '0) && !push_credit_stall && !lane_rst;

  assign count_next = count_q
                    + {{(credit_rx_pkg::CNT_W-1){1'b0}}, lane.deq}
                    - {{(credit_rx_pkg::CNT_W-1){1'b0}}, credit_grant};

  // Reset reloads the full credit budget, since the buffer is emptied at
  // the same time.
  always_ff @(posedge clk) begin
    if (lane_rst) begin
      count_q <= credit_rx_pkg::CNT_W'(credit_rx_pkg::LANE_DEPTH);
    end else begin
      count_q <= count_next;
    end
  end

  assign push_credit = credit_grant;

  // Reported before this cycle's grant and dequeue are applied.
  assign credit_count = count_q;

endmodule : credit_lane

`default_nettype wire

// ==== hdl/flow_demux.sv ====
`timescale 1ns/10ps
`default_nettype none

module flow_demux (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           lane_rst,
  input  wire logic                           push_valid,
  input  wire logic [credit_rx_pkg::FLOW_W-1:0] push_flow,
  input  wire credit_rx_pkg::payload_t        push_data,
  lane_if.demux                               lanes [credit_rx_pkg::NUM_FLOWS]
);

  // ----------------------------------------------------------------------
  // Push gating
  // ----------------------------------------------------------------------

  // Remembers that the lanes were in reset during the previous cycle.
  // Credits come out combinationally, so a sender cannot push against a
  // credit of the new epoch before the second cycle out of reset.
  // Anything that arrives in the first cycle is left over from before
  // the reset and is dropped along with the pushes made in reset.
  logic rst_hold_q;

  // Push strobe after all reset gating.
  logic push_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_hold_q <= 1'b1;
    end else begin
      rst_hold_q <= lane_rst;
    end
  end

  assign push_ok = push_valid && !lane_rst && !rst_hold_q;

  // ----------------------------------------------------------------------
  // Flow decode
  // ----------------------------------------------------------------------

  // Each lane sees the shared data bus, but only the lane named by the
  // flow number gets the strobe, so the decode is one-hot.
  for (genvar i = 0; i < credit_rx_pkg::NUM_FLOWS; i++) begin : g_steer
    assign lanes[i].push_valid = push_ok &&
                                 (push_flow == credit_rx_pkg::FLOW_W'(i));
    assign lanes[i].push_data  = push_data;
  end

endmodule : flow_demux

`default_nettype wire

// ==== hdl/lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Bundle for one receive lane.
// The demux writes into the lane, the arbiter drains it.
interface lane_if;

  // ----------------------------------------------------------------------
  // Push side, driven by the flow demux
  // ----------------------------------------------------------------------

  // One-cycle strobe, high when an item for this lane is pushed.
  logic                     push_valid;
  // Item that goes with push_valid.
  credit_rx_pkg::payload_t  push_data;

  // ----------------------------------------------------------------------
  // Pop side, shared between the lane and the arbiter
  // ----------------------------------------------------------------------

  // Dequeue strobe from the arbiter.
  // It is only raised while head_valid is high.
  logic                     deq;
  // High while the lane buffer holds at least one entry.
  logic                     head_valid;
  // Oldest entry in the lane buffer, valid with head_valid.
  credit_rx_pkg::payload_t  head_data;

  // The demux only writes the push fields.
  modport demux (
    output push_valid,
    output push_data
  );

  // The lane stores pushes and exposes its oldest entry.
  modport lane (
    input  push_valid,
    input  push_data,
    input  deq,
    output head_valid,
    output head_data
  );

  // The arbiter looks at the head and pulls it out.
  modport arb (
    output deq,
    input  head_valid,
    input  head_data
  );

endinterface : lane_if

`default_nettype wire

// ==== hdl/credit_rx_pkg.sv ====
`default_nettype none

package credit_rx_pkg;

  // ----------------------------------------------------------------------
  // Link sizes
  // ----------------------------------------------------------------------

  // Number of independent flows sharing the push port, one lane per flow.
  localparam int NUM_FLOWS = 4;

  // Width of the flow number carried with every push and pop.
  localparam int FLOW_W = 2;

  // Width of the payload word.
  localparam int DATA_W = 16;

  // Buffer entries per lane.
  // This is also the credit count each lane starts with after reset.
  // The lane buffer uses wrap-bit pointers, so keep this a power of two.
  localparam int LANE_DEPTH = 4;

  // Width of the credit counter and of the withhold amount.
  // It must be able to hold LANE_DEPTH itself.
  localparam int CNT_W = 3;

  // Index width of the lane buffer, without the wrap bit.
  localparam int PTR_W = $clog2(LANE_DEPTH);

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------

  // One item carried by the link.
  typedef logic [DATA_W-1:0] payload_t;

endpackage : credit_rx_pkg

`default_nettype wire
